// File: hw/isaPkg.sv
package isaPkg;

  localparam int instrWidth = 32;

  // field positions inside the instruction word
  localparam int opcodeMsb = 31;
  localparam int opcodeLsb = 26;
  localparam int rtMsb = 20;
  localparam int rtLsb = 16;
  localparam int functMsb = 5;
  localparam int functLsb = 0;

  localparam int opcodeWidth = opcodeMsb - opcodeLsb + 1;
  localparam int rtWidth = rtMsb - rtLsb + 1;
  localparam int functWidth = functMsb - functLsb + 1;

  // primary opcodes handled by the control unit
  typedef enum logic [opcodeWidth-1:0] {
    RTYPE  = 6'b000000,
    REGIMM = 6'b000001, // branch picked by rt
    J      = 6'b000010,
    JAL    = 6'b000011,
    BEQ    = 6'b000100,
    BNE    = 6'b000101,
    BGTZ   = 6'b000111,
    ADDIU  = 6'b001001,
    SLTI   = 6'b001010,
    SLTIU  = 6'b001011,
    ANDI   = 6'b001100,
    ORI    = 6'b001101,
    LW     = 6'b100011,
    SW     = 6'b101011
  } opcodeT;

  // funct field of RTYPE
  typedef enum logic [functWidth-1:0] {
    JR   = 6'b001000,
    JALR = 6'b001001,
    ADDU = 6'b100001,
    AND  = 6'b100100,
    OR   = 6'b100101
  } functT;

  // rt field of REGIMM
  typedef enum logic [rtWidth-1:0] {
    BGEZ = 5'b00001,
    BLEZ = 5'b00110
  } regimmT;

endpackage

// File: hw/ctrlPkg.sv
package ctrlPkg;

  // multicycle sequence states
  typedef enum logic [2:0] {
    FETCH  = 3'b000,
    DECODE = 3'b001,
    EXEC1  = 3'b010,
    EXEC2  = 3'b011,
    EXEC3  = 3'b100,
    HALTED = 3'b101,
    STALL  = 3'b110
  } stateT;

  // operation codes understood by the datapath ALU
  typedef enum logic [4:0] {
    AluAnd      = 5'b00000,
    AluOr       = 5'b00001,
    AluAdd      = 5'b00010,
    AluSlt      = 5'b00111,
    AluSltu     = 5'b01001,
    AluEq       = 5'b01010, // lsb set when operands equal
    AluPassB    = 5'b01011,
    AluSignTest = 5'b01100, // lsb set when A is zero or negative
    AluUpperImm = 5'b01101, // pc plus shifted offset
    AluPassA    = 5'b01110,
    AluRfunct   = 5'b01111  // ALU decodes the funct field itself
  } aluOpT;

  // second ALU operand
  typedef enum logic [1:0] {
    SrcBReg        = 2'b00,
    SrcBFour       = 2'b01,
    SrcBImm        = 2'b10,
    SrcBJumpTarget = 2'b11
  } srcBT;

  // how a branch or jump resolves against the ALU result lsb
  typedef enum logic [1:0] {
    BrNone       = 2'b00,
    BrAlways     = 2'b01,
    BrIfLsbSet   = 2'b10,
    BrIfLsbClear = 2'b11
  } branchKindT;

endpackage

// File: hw/controlFsm.sv
`timescale 1ns/1ps

module controlFsm
  import ctrlPkg::*;
(
  input  logic  clk,
  input  logic  rstN,
  input  logic  run,
  input  logic  waitRequest,
  input  logic  aluStall,
  input  logic  extra,
  output stateT state,
  output logic  active
);

  stateT stateNext;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= HALTED;
    end else begin
      state <= stateNext;
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      HALTED: begin
        if (run) begin
          stateNext = FETCH;
        end
      end
      // memory may stretch the instruction fetch
      FETCH, STALL: begin
        stateNext = waitRequest ? STALL : DECODE;
      end
      DECODE: begin
        stateNext = EXEC1;
      end
      EXEC1: begin
        if (!aluStall) begin
          stateNext = extra ? EXEC2 : FETCH;
        end
      end
      EXEC2: begin
        if (!waitRequest) begin // data access still pending otherwise
          stateNext = extra ? EXEC3 : FETCH;
        end
      end
      EXEC3: begin
        stateNext = FETCH;
      end
      default: begin
        stateNext = HALTED;
      end
    endcase
  end

  assign active = (state != HALTED);

endmodule

// File: hw/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder
  import isaPkg::*, ctrlPkg::*;
(
  input  logic [instrWidth-1:0] instr,
  input  stateT                 state,
  output logic                  extra,
  output logic                  aluSrcA,
  output srcBT                  aluSrcB,
  output aluOpT                 aluControl,
  output logic                  extSel,
  output logic                  aluSel,
  output logic                  regDst,
  output logic                  wbFromAlu,
  output logic                  regWrite,
  output logic                  iorD,
  output logic                  memRead,
  output logic                  memWrite,
  output logic                  pcWrite,
  output logic                  irWrite,
  output logic                  isJump,
  output logic                  link,
  output branchKindT            branchKind,
  output logic                  branchLoad
);

  opcodeT opcode;
  functT  funct;
  regimmT rtCode;
  logic   isExec;

  assign opcode = opcodeT'(instr[opcodeMsb:opcodeLsb]);
  assign funct  = functT'(instr[functMsb:functLsb]);
  assign rtCode = regimmT'(instr[rtMsb:rtLsb]);
  assign isExec = (state == EXEC1) || (state == EXEC2) || (state == EXEC3);

  // bus strobes
  assign pcWrite  = (state == FETCH);
  assign irWrite  = (state == DECODE);
  assign memRead  = (state == FETCH) || (state == STALL) || (opcode == LW && state == EXEC2);
  assign memWrite = (opcode == SW) && (state == EXEC2);
  assign isJump   = (opcode == J || opcode == JAL) && (state == EXEC1);
  assign link     = (opcode == JAL) && (state == EXEC1);

  always_comb begin
    // pc + 4 path unless overridden below
    extra      = 1'b0;
    aluSrcA    = 1'b0;
    aluSrcB    = SrcBFour;
    aluControl = AluAdd;
    extSel     = 1'b0;
    aluSel     = 1'b0;
    regDst     = 1'b0;
    wbFromAlu  = 1'b1;
    regWrite   = 1'b0;
    iorD       = 1'b0;
    branchKind = BrNone;
    branchLoad = 1'b0;

    if (state == DECODE) begin
      aluSrcB = SrcBJumpTarget;
      if (opcode == J || opcode == JAL) begin
        extSel     = 1'b1; // jump index form
        aluControl = AluPassB;
      end else begin
        aluControl = AluUpperImm; // branch target into ALU register
      end
    end else if (isExec) begin
      case (opcode)
        RTYPE: begin
          case (funct)
            JR: begin
              if (state == EXEC1) begin
                aluSrcA    = 1'b1;
                aluControl = AluPassA;
                branchKind = BrAlways;
                branchLoad = 1'b1;
              end
            end
            JALR: begin
              if (state == EXEC1) begin // return address pc + 4
                regDst   = 1'b1;
                regWrite = 1'b1;
                extra    = 1'b1;
              end else if (state == EXEC2) begin
                aluSrcA    = 1'b1;
                aluControl = AluPassA;
                branchKind = BrAlways;
                branchLoad = 1'b1;
              end
            end
            ADDU, AND, OR: begin
              if (state == EXEC1) begin
                aluSrcA    = 1'b1;
                aluSrcB    = SrcBReg;
                aluControl = AluRfunct;
                extra      = 1'b1;
              end else if (state == EXEC2) begin
                aluSel   = 1'b1;
                regDst   = 1'b1;
                regWrite = 1'b1;
              end
            end
            default: ;
          endcase
        end
        LW, SW: begin
          if (state == EXEC1) begin // effective address
            aluSrcA = 1'b1;
            aluSrcB = SrcBImm;
            extra   = 1'b1;
          end else if (state == EXEC2) begin
            iorD   = 1'b1;
            aluSel = 1'b1;
            extra  = (opcode == LW);
          end else if (state == EXEC3) begin
            wbFromAlu = 1'b0; // load data back to rt
            regWrite  = 1'b1;
          end
        end
        ADDIU, ANDI, ORI, SLTI, SLTIU: begin
          if (state == EXEC1) begin
            aluSrcA = 1'b1;
            aluSrcB = SrcBImm;
            extra   = 1'b1;
            case (opcode)
              ANDI: begin
                aluControl = AluAnd;
                extSel     = 1'b1; // zero extend
              end
              ORI: begin
                aluControl = AluOr;
                extSel     = 1'b1;
              end
              SLTI:    aluControl = AluSlt;
              SLTIU:   aluControl = AluSltu;
              default: aluControl = AluAdd;
            endcase
          end else if (state == EXEC2) begin
            aluSel   = 1'b1;
            regWrite = 1'b1;
          end
        end
        BEQ, BNE: begin
          if (state == EXEC1) begin
            aluSrcA    = 1'b1;
            aluSrcB    = SrcBReg;
            aluControl = AluEq;
            aluSel     = 1'b1;
            branchKind = (opcode == BEQ) ? BrIfLsbSet : BrIfLsbClear;
            branchLoad = 1'b1;
          end
        end
        BGTZ: begin
          if (state == EXEC1) begin // taken when not (rs <= 0)
            aluSrcA    = 1'b1;
            aluControl = AluSignTest;
            aluSel     = 1'b1;
            branchKind = BrIfLsbClear;
            branchLoad = 1'b1;
          end
        end
        REGIMM: begin
          if (state == EXEC1 && (rtCode == BLEZ || rtCode == BGEZ)) begin
            aluSrcA    = 1'b1;
            aluControl = AluSignTest;
            aluSel     = 1'b1;
            branchKind = (rtCode == BLEZ) ? BrIfLsbSet : BrIfLsbClear;
            branchLoad = 1'b1;
          end
        end
        J: begin
          if (state == EXEC1) begin
            aluSrcB    = SrcBJumpTarget;
            aluControl = AluPassB;
            extSel     = 1'b1;
            aluSel     = 1'b1;
            branchKind = BrAlways;
            branchLoad = 1'b1;
          end
        end
        JAL: begin
          if (state == EXEC1) begin // link value pc + 4 straight from ALU
            extSel     = 1'b1;
            branchKind = BrAlways;
            branchLoad = 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

// File: hw/branchDelayTracker.sv
`timescale 1ns/1ps

module branchDelayTracker
  import ctrlPkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  input  stateT      state,
  input  logic       branchLoad,
  input  branchKindT branchKind,
  input  logic       outLsb,
  output logic       pcSrc,
  output logic       branchDelay
);

  logic taken;
  logic pending; // redirect owed to the next fetch

  always_comb begin
    case (branchKind)
      BrAlways:     taken = 1'b1;
      BrIfLsbSet:   taken = outLsb;
      BrIfLsbClear: taken = !outLsb;
      default:      taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pending <= 1'b0;
    end else if (branchLoad) begin
      pending <= taken;
    end else if (state == FETCH) begin
      // pc already redirected on this edge
      pending <= 1'b0;
    end
  end

  assign branchDelay = pending;
  assign pcSrc       = pending && (state == FETCH);

endmodule

// File: hw/cpuControl.sv
`timescale 1ns/1ps

module cpuControl
  import isaPkg::*, ctrlPkg::*;
(
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  run,
  input  logic [instrWidth-1:0] instr,
  input  logic                  waitRequest,
  input  logic                  aluStall,
  input  logic                  outLsb,
  output logic                  aluSrcA,
  output srcBT                  aluSrcB,
  output aluOpT                 aluControl,
  output logic                  extSel,
  output logic                  aluSel,
  output logic                  regDst,
  output logic                  wbFromAlu,
  output logic                  regWrite,
  output logic                  iorD,
  output logic                  memRead,
  output logic                  memWrite,
  output logic                  pcWrite,
  output logic                  irWrite,
  output logic                  isJump,
  output logic                  link,
  output stateT                 state,
  output logic                  active,
  output logic                  pcSrc,
  output logic                  branchDelay
);

  logic       extra;
  logic       branchLoad;
  branchKindT branchKind;

  controlFsm u_controlFsm (
    .clk         (clk),
    .rstN        (rstN),
    .run         (run),
    .waitRequest (waitRequest),
    .aluStall    (aluStall),
    .extra       (extra),
    .state       (state),
    .active      (active)
  );

  instrDecoder u_instrDecoder (
    .instr      (instr),
    .state      (state),
    .extra      (extra),
    .aluSrcA    (aluSrcA),
    .aluSrcB    (aluSrcB),
    .aluControl (aluControl),
    .extSel     (extSel),
    .aluSel     (aluSel),
    .regDst     (regDst),
    .wbFromAlu  (wbFromAlu),
    .regWrite   (regWrite),
    .iorD       (iorD),
    .memRead    (memRead),
    .memWrite   (memWrite),
    .pcWrite    (pcWrite),
    .irWrite    (irWrite),
    .isJump     (isJump),
    .link       (link),
    .branchKind (branchKind),
    .branchLoad (branchLoad)
  );

  branchDelayTracker u_branchDelayTracker (
    .clk         (clk),
    .rstN        (rstN),
    .state       (state),
    .branchLoad  (branchLoad),
    .branchKind  (branchKind),
    .outLsb      (outLsb),
    .pcSrc       (pcSrc),
    .branchDelay (branchDelay)
  );

endmodule

// File: verif/cpuControl_assertions.sv
`timescale 1ns/1ps

module cpuControlAssertions
  import isaPkg::*, ctrlPkg::*;
(
  input logic                  clk,
  input logic                  rstN,
  input logic                  run,
  input logic [instrWidth-1:0] instr,
  input logic                  waitRequest,
  input logic                  aluStall,
  input logic                  outLsb,
  input logic                  aluSrcA,
  input srcBT                  aluSrcB,
  input aluOpT                 aluControl,
  input logic                  extSel,
  input logic                  aluSel,
  input logic                  regDst,
  input logic                  wbFromAlu,
  input logic                  regWrite,
  input logic                  iorD,
  input logic                  memRead,
  input logic                  memWrite,
  input logic                  pcWrite,
  input logic                  irWrite,
  input logic                  isJump,
  input logic                  link,
  input stateT                 state,
  input logic                  active,
  input logic                  pcSrc,
  input logic                  branchDelay
);

  int errorCount = 0; // polled by the testbench

  logic [opcodeWidth-1:0] op;
  logic [functWidth-1:0]  fn;
  logic [rtWidth-1:0]     rt;
  logic isLoad;
  logic isStore;
  logic isAluR;
  logic isJalr;
  logic isImm;
  logic takenNow;
  logic stallNow;
  int   steps;

  logic tracking; // from irWrite up to the next fetch
  logic expPcSrc;
  logic regWritePrev;
  int   span;
  int   stalls;
  int   rises;
  int   expSteps;
  int   expRises;
  int   stepNow; // exec step from the sequence rules, 0 outside exec

  assign op = instr[opcodeMsb:opcodeLsb];
  assign fn = instr[functMsb:functLsb];
  assign rt = instr[rtMsb:rtLsb];

  // instruction classes
  assign isLoad  = (op == LW);
  assign isStore = (op == SW);
  assign isJalr  = (op == RTYPE) && (fn == JALR);
  assign isAluR  = (op == RTYPE) && (fn == ADDU || fn == AND || fn == OR);
  assign isImm   = op inside {ADDIU, ANDI, ORI, SLTI, SLTIU};
  assign steps   = isLoad ? 3 : (isAluR || isJalr || isImm || isStore) ? 2 : 1;

  // extra cycles caused by the stall inputs
  assign stallNow = (state == EXEC1 && aluStall) || (state == EXEC2 && waitRequest);

  always_comb begin
    takenNow = 1'b0;
    if (op == J || op == JAL || (op == RTYPE && (fn == JR || fn == JALR))) begin
      takenNow = 1'b1;
    end else if (op == BEQ || (op == REGIMM && rt == BLEZ)) begin
      takenNow = outLsb;
    end else if (op == BNE || op == BGTZ || (op == REGIMM && rt == BGEZ)) begin
      takenNow = !outLsb;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      tracking     <= 1'b0;
      expPcSrc     <= 1'b0;
      regWritePrev <= 1'b0;
      span         <= 0;
      stalls       <= 0;
      rises        <= 0;
      expSteps     <= 0;
      expRises     <= 0;
      stepNow      <= 0;
    end else begin
      regWritePrev <= regWrite;
      if (irWrite) begin
        tracking <= 1'b1;
        expPcSrc <= 1'b0;
        span     <= 1;
        stalls   <= 0;
        rises    <= 0;
        expSteps <= steps;
        expRises <= (isLoad || isAluR || isJalr || isImm) ? 1 : 0;
      end else if (tracking) begin
        span <= span + 1;
        if (stallNow) begin
          stalls <= stalls + 1;
        end
        if (regWrite && !regWritePrev) begin
          rises <= rises + 1;
        end
        if (state == EXEC1 && !aluStall) begin
          expPcSrc <= takenNow; // condition resolves on the EXEC1 exit edge
        end
        if (pcWrite) begin
          tracking <= 1'b0;
        end
      end
      // EXEC1 waits on aluStall, EXEC2 on waitRequest
      if (irWrite) begin
        stepNow <= 1;
      end else if (stepNow == 1 && !aluStall) begin
        stepNow <= (expSteps > 1) ? 2 : 0;
      end else if (stepNow == 2 && !waitRequest) begin
        stepNow <= (expSteps > 2) ? 3 : 0;
      end else if (stepNow == 3) begin
        stepNow <= 0;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rstN)
    state == HALTED |-> !active && !pcWrite && !memRead && !memWrite && !regWrite && !irWrite)
  else begin
    errorCount++;
    $error("control strobe or active set while halted");
  end

  assert property (@(posedge clk) disable iff (!rstN)
    state == HALTED && run |=> state == FETCH && pcWrite && memRead)
  else begin
    errorCount++;
    $error("fetch did not start on the first edge with run high");
  end

  assert property (@(posedge clk) disable iff (!rstN)
    (state == FETCH || state == STALL) |-> memRead && !irWrite)
  else begin
    errorCount++;
    $error("memRead low or irWrite high during instruction fetch");
  end

  assert property (@(posedge clk) disable iff (!rstN)
    (state == FETCH || state == STALL) && !waitRequest |=> irWrite)
  else begin
    errorCount++;
    $error("irWrite missing after fetch completed");
  end

  assert property (@(posedge clk) disable iff (!rstN) irWrite |=> !irWrite)
  else begin
    errorCount++;
    $error("irWrite held longer than one cycle");
  end

  assert property (@(posedge clk) disable iff (!rstN)
    tracking && pcWrite |-> span == expSteps + stalls + 1)
  else begin
    errorCount++;
    $error("Mismatch span: got %h expected %h", $sampled(span),
           $sampled(expSteps) + $sampled(stalls) + 1);
  end

  assert property (@(posedge clk) disable iff (!rstN)
    state == EXEC1 && aluStall |=>
      state == EXEC1 && $stable(aluSrcA) && $stable(aluSrcB) && $stable(aluControl) &&
      $stable(extSel) && $stable(aluSel) && $stable(iorD))
  else begin
    errorCount++;
    $error("EXEC1 not held with stable selects under aluStall");
  end

  assert property (@(posedge clk) disable iff (!rstN)
    memWrite == (stepNow == 2 && isStore))
  else begin
    errorCount++;
    $error("Mismatch memWrite: got %h expected %h", $sampled(memWrite),
           $sampled(stepNow == 2 && isStore));
  end

  assert property (@(posedge clk) disable iff (!rstN) stepNow == 2 && isLoad |-> memRead)
  else begin
    errorCount++;
    $error("memRead missing in the data step of a load");
  end

  // data accesses use the ALU address, fetches the pc
  assert property (@(posedge clk) disable iff (!rstN)
    memRead || memWrite |-> iorD == (stepNow == 2))
  else begin
    errorCount++;
    $error("Mismatch iorD: got %h expected %h", $sampled(iorD), $sampled(stepNow == 2));
  end

  assert property (@(posedge clk) disable iff (!rstN)
    tracking && pcWrite |-> rises == expRises)
  else begin
    errorCount++;
    $error("Mismatch regWrite rises: got %h expected %h", $sampled(rises), $sampled(expRises));
  end

  assert property (@(posedge clk) disable iff (!rstN)
    regWrite && !regWritePrev |-> regDst == (isAluR || isJalr) && wbFromAlu == !isLoad)
  else begin
    errorCount++;
    $error("Mismatch regDst/wbFromAlu: got %h/%h expected %h/%h", $sampled(regDst),
           $sampled(wbFromAlu), $sampled(isAluR || isJalr), $sampled(!isLoad));
  end

  assert property (@(posedge clk) disable iff (!rstN)
    pcWrite |-> pcSrc == (tracking && expPcSrc) && branchDelay == (tracking && expPcSrc))
  else begin
    errorCount++;
    $error("Mismatch pcSrc/branchDelay: got %h/%h expected %h", $sampled(pcSrc),
           $sampled(branchDelay), $sampled(tracking && expPcSrc));
  end

  assert property (@(posedge clk) disable iff (!rstN) irWrite |-> !branchDelay)
  else begin
    errorCount++;
    $error("Mismatch branchDelay: got %h expected 0", $sampled(branchDelay));
  end

  assert property (@(posedge clk) disable iff (!rstN)
    isJump == (stepNow == 1 && (op == J || op == JAL)) &&
    link == (stepNow == 1 && op == JAL))
  else begin
    errorCount++;
    $error("Mismatch isJump/link: got %h/%h expected %h/%h", $sampled(isJump),
           $sampled(link), $sampled(stepNow == 1 && (op == J || op == JAL)),
           $sampled(stepNow == 1 && op == JAL));
  end

endmodule

bind cpuControl cpuControlAssertions u_cpuControlAssertions (.*);

// File: verif/cpuControlTb.sv
`timescale 1ns/1ps

module cpuControlTb
  import isaPkg::*, ctrlPkg::*;
();

  localparam int listSize   = 19;
  localparam int rounds     = 3;
  localparam int fetchLimit = 64;   // cycles allowed per instruction
  localparam int maxCycles  = 4000; // whole run

  logic                  clk;
  logic                  rstN;
  logic                  run;
  logic [instrWidth-1:0] instr;
  logic                  waitRequest;
  logic                  aluStall;
  logic                  outLsb;
  logic                  aluSrcA;
  srcBT                  aluSrcB;
  aluOpT                 aluControl;
  logic                  extSel;
  logic                  aluSel;
  logic                  regDst;
  logic                  wbFromAlu;
  logic                  regWrite;
  logic                  iorD;
  logic                  memRead;
  logic                  memWrite;
  logic                  pcWrite;
  logic                  irWrite;
  logic                  isJump;
  logic                  link;
  stateT                 state;
  logic                  active;
  logic                  pcSrc;
  logic                  branchDelay;

  logic [instrWidth-1:0] instrList [listSize];

  cpuControl u_cpuControl (.*);

  function automatic logic [31:0] nextRandom(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [instrWidth-1:0] rFormat(input functT f);
    return {RTYPE, 5'd4, 5'd5, 5'd6, 5'd0, f};
  endfunction

  function automatic logic [instrWidth-1:0] iFormat(input opcodeT opc, input logic [15:0] imm);
    return {opc, 5'd4, 5'd5, imm};
  endfunction

  function automatic logic [instrWidth-1:0] regimmFormat(input regimmT rtc);
    return {REGIMM, 5'd4, rtc, 16'h0008};
  endfunction

  function automatic logic [instrWidth-1:0] jFormat(input opcodeT opc);
    return {opc, 26'h0000040};
  endfunction

  // returns at a negedge inside a FETCH cycle
  task automatic waitForFetch(input int limit);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!pcWrite) begin
      if (cycles >= limit) begin
        $display("Testbench failed");
        $fatal(1, "no instruction fetch within %0d cycles", limit);
      end else begin
        cycles++;
        @(negedge clk);
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // memory and ALU status, fresh every edge
  initial begin
    logic [31:0] rnd;
    rnd = 32'h897f;
    waitRequest = 1'b0;
    aluStall = 1'b0;
    outLsb = 1'b0;
    forever begin
      @(posedge clk);
      rnd = nextRandom(rnd);
      waitRequest <= (rnd[1:0] == 2'b00);
      aluStall <= (rnd[3:2] == 2'b00);
      outLsb <= rnd[4];
    end
  end

  initial begin
    int cycles;
    cycles = 0;
    while (u_cpuControl.u_cpuControlAssertions.errorCount == 0 && cycles < maxCycles) begin
      @(negedge clk);
      cycles++;
    end
    $display("Testbench failed");
    if (u_cpuControl.u_cpuControlAssertions.errorCount != 0) begin
      $fatal(1, "an assertion on the DUT outputs fired");
    end else begin
      $fatal(1, "run did not finish within %0d cycles", maxCycles);
    end
  end

  initial begin
    rstN = 1'b0;
    run = 1'b0;
    instr = '0;
    instrList = '{rFormat(ADDU), rFormat(AND), rFormat(OR), rFormat(JR), rFormat(JALR),
                  iFormat(LW, 16'h0004), iFormat(SW, 16'h0008), iFormat(ADDIU, 16'hfff0),
                  iFormat(ANDI, 16'h00ff), iFormat(ORI, 16'h0f00), iFormat(SLTI, 16'h0010),
                  iFormat(SLTIU, 16'h0020), iFormat(BEQ, 16'h0003), iFormat(BNE, 16'hfffd),
                  iFormat(BGTZ, 16'h0002), regimmFormat(BLEZ), regimmFormat(BGEZ),
                  jFormat(J), jFormat(JAL)};
    repeat (2) @(posedge clk);
    rstN <= 1'b1;
    repeat (3) @(posedge clk); // idle in HALTED with run low
    run <= 1'b1;
    for (int round = 0; round < rounds; round++) begin
      for (int i = 0; i < listSize; i++) begin
        waitForFetch(fetchLimit);
        @(posedge clk);
        instr <= instrList[i]; // word is valid from DECODE on
      end
    end
    waitForFetch(fetchLimit);
    repeat (2) @(negedge clk);
    if (u_cpuControl.u_cpuControlAssertions.errorCount == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("Testbench failed");
      $fatal(1, "assertion errors were counted");
    end
  end

endmodule

// File: cpuControl.f
hw/isaPkg.sv
hw/ctrlPkg.sv
hw/controlFsm.sv
hw/instrDecoder.sv
hw/branchDelayTracker.sv
hw/cpuControl.sv
verif/cpuControl_assertions.sv
verif/cpuControlTb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f cpuControl.f --top-module cpuControlTb \
  -o simCpuControl > build.log 2>&1 \
  && ./obj_dir/simCpuControl > sim.log 2>&1 \
  || echo "build or simulation exited with an error" >> sim.log
grep -q "Testbench failed" sim.log && { echo "FAIL (see sim.log)"; exit 1; }
grep -q "Testbench passed" sim.log && echo "PASS" || { echo "FAIL (see sim.log)"; exit 1; }
